/* Makefile */
# Verilator build for the dual-clock FIFO
# every variable can be overridden, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= afifo_tb
RTL_TOP   ?= afifo_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
JOBS      ?= 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all lint sim clean

all: sim

# lint the design on its own and then with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FLIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulation is the pass or fail result
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* bench/afifo_tb.sv */
// --------------------------------------------------
// testbench for the dual-clock FIFO with phase table, queue model,
// two drifting clocks, timeout and value checks
// --------------------------------------------------
`timescale 1ns/1ps

module afifo_tb;

   import afifo_pkg::*;

   localparam int SYNC_STAGES   = 2;
   localparam int NUM_PHASES    = 4;
   localparam int SETTLE_CYCLES = 8;    // write cycles for pointers to cross back
   localparam int MARGIN        = 200;  // read cycles for reset, settle waits and slack

   // one row of the stimulus table
   typedef struct packed {
      int   n_push;     // push attempts in this phase
      int   push_pct;   // chance of a push per write cycle
      int   ready_pct;  // chance of read_ready per read cycle
      int   budget;     // read cycles allowed
      int   exp_left;   // words still queued at the end
      logic exp_full;   // full at the end
      int   exp_pops;   // words read in the phase or -1 when not counted
   } phase_t;

   logic  write_clk = 1'b0;
   logic  read_clk  = 1'b0;
   logic  write_rst_n;
   logic  read_rst_n;
   logic  push;
   logic  read_ready;
   data_t push_data;
   logic  full;
   logic  rd_valid;
   data_t rd_data;

   phase_t      phases [NUM_PHASES];
   string       phase_names [NUM_PHASES];
   string       phase_name = "reset";
   data_t       model_q [$];             // words accepted but not yet read
   logic [31:0] rng_state = 32'h19db2ab8;
   int          cycle_count = 0;
   int          cycle_limit = 1000000;   // replaced once the table is loaded
   int          phase_pops;
   logic        writes_done;
   logic        hold_valid = 1'b0;       // head word was stalled last read edge
   data_t       hold_data;

   afifo_top #(.SYNC_STAGES(SYNC_STAGES)) afifo_top_i (
      .write_clk   (write_clk),
      .write_rst_n (write_rst_n),
      .push        (push),
      .push_data   (push_data),
      .full        (full),
      .read_clk    (read_clk),
      .read_rst_n  (read_rst_n),
      .read_ready  (read_ready),
      .rd_valid    (rd_valid),
      .rd_data     (rd_data)
   );

   always #4   read_clk  = ~read_clk;   // 8 ns
   always #5.5 write_clk = ~write_clk;  // 11 ns so it drifts against read_clk

   // xorshift32 stream shared by data, push and ready
   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Fail %s %s: expected %0h, actual %0h",
                  phase_name, what, expected, actual);
         $display("Test failed");
         $fatal(1, "value mismatch");
      end
   endtask

   // ---- queue model ----------------------------------
   always @(posedge write_clk) begin
      if (write_rst_n && push && !full) begin
         model_q.push_back(push_data);  // accepted on this edge
         if (model_q.size() > 4) begin
            $display("more than 4 words were accepted without a read");
            $display("Test failed");
            $fatal(1, "overfill");
         end
      end
   end

   always @(posedge read_clk) begin
      if (read_rst_n) begin
         if (!rd_valid)
            check_value("rd_data while empty", 32'h0, 32'(rd_data));
         else if (hold_valid)
            check_value("rd_data while stalled", 32'(hold_data), 32'(rd_data));
         if (rd_valid && read_ready) begin
            if (model_q.size() == 0) begin
               $display("the FIFO handed out a word that was never pushed");
               $display("Test failed");
               $fatal(1, "underflow");
            end else begin
               check_value("rd_data", 32'(model_q.pop_front()), 32'(rd_data));
               phase_pops = phase_pops + 1;
            end
         end
         hold_valid = rd_valid && !read_ready;
         hold_data  = rd_data;
      end
   end

   // timeout on the read clock
   always @(posedge read_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: run still busy after %0d read cycles", cycle_count);
         $display("Test failed");
         $fatal(1, "timeout");
      end
   end

   // ---- stimulus -------------------------------------
   task automatic drive_writes(input int n, input int pct);
      int          sent;
      logic [31:0] r;
      sent = 0;
      while (sent < n) begin
         @(posedge write_clk);
         r = next_rand();
         if (r % 100 < 32'(pct)) begin
            push      <= 1'b1;
            push_data <= r[15:8];
            sent++;
         end else begin
            push <= 1'b0;
         end
      end
      @(posedge write_clk);  // last push is sampled here
      push <= 1'b0;
   endtask

   // runs until the writes are done and the model has drained
   // with rd_valid low no word leaves on this edge, so the queue size is settled
   task automatic drive_reads(input int pct);
      logic done;
      done = 1'b0;
      while (!done) begin
         @(posedge read_clk);
         if (writes_done && (pct == 0 || (!rd_valid && model_q.size() == 0))) begin
            read_ready <= 1'b0;
            done = 1'b1;
         end else begin
            read_ready <= (next_rand() % 100 < 32'(pct));
         end
      end
   endtask

   function automatic void load_table();
      phase_names[0] = "steady";  // constant flow, some pushes meet full
      phases[0] = '{12, 100, 100, 150, 0, 1'b0, -1};
      phase_names[1] = "fill";    // no reads and pushes past full are dropped
      phases[1] = '{8, 100, 0, 80, 4, 1'b1, 0};
      phase_names[2] = "drain";   // exactly the 4 accepted words come back
      phases[2] = '{0, 0, 100, 60, 0, 1'b0, 4};
      phase_names[3] = "random";  // pointer wrap in both domains
      phases[3] = '{48, 60, 50, 700, 0, 1'b0, -1};
   endfunction

   // ---- main sequence --------------------------------
   initial begin
      phase_t ph;
      write_rst_n = 1'b0;
      read_rst_n  = 1'b0;
      push        = 1'b0;
      push_data   = '0;
      read_ready  = 1'b0;
      phase_pops  = 0;
      writes_done = 1'b0;
      load_table();
      cycle_limit = MARGIN;
      for (int i = 0; i < NUM_PHASES; i++) begin
         cycle_limit += phases[i].budget;
      end

      fork
         begin
            repeat (4) @(posedge write_clk);
            write_rst_n <= 1'b1;
         end
         begin
            repeat (4) @(posedge read_clk);
            read_rst_n <= 1'b1;
         end
      join
      repeat (2) @(posedge read_clk);
      @(negedge read_clk);
      check_value("rd_valid after reset", 32'h0, 32'(rd_valid));
      check_value("rd_data after reset", 32'h0, 32'(rd_data));
      @(negedge write_clk);
      check_value("full after reset", 32'h0, 32'(full));

      for (int i = 0; i < NUM_PHASES; i++) begin
         ph          = phases[i];
         phase_name  = phase_names[i];
         phase_pops  = 0;
         writes_done = 1'b0;
         fork
            begin
               drive_writes(ph.n_push, ph.push_pct);
               writes_done = 1'b1;
            end
            drive_reads(ph.ready_pct);
         join
         repeat (SETTLE_CYCLES) @(posedge write_clk);  // let both pointers cross
         @(negedge write_clk);
         check_value("full at end", 32'(ph.exp_full), 32'(full));
         @(negedge read_clk);
         check_value("rd_valid at end", 32'(ph.exp_left != 0), 32'(rd_valid));
         check_value("words queued", 32'(ph.exp_left), 32'(model_q.size()));
         if (ph.exp_pops != -1)
            check_value("words read", 32'(ph.exp_pops), 32'(phase_pops));
      end

      $display("Test completed successfully");
      $finish;
   end

endmodule

/* flist.f */
+incdir+include
source/afifo_pkg.sv
source/gray_ptr_sync.sv
source/afifo_regfile.sv
source/afifo_write_ctrl.sv
source/afifo_read_ctrl.sv
source/afifo_top.sv
bench/afifo_tb.sv

/* include/fifo_defs.svh */
// --------------------------------------------------
// width constants shared by the dual-clock FIFO
// --------------------------------------------------
`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

// address width, 4 entries deep
localparam int FIFO_AW = 2;

// data word width
localparam int FIFO_DW = 8;

// pointer width, one extra bit to tell full from empty
localparam int FIFO_PW = FIFO_AW + 1;

`endif

/* source/afifo_pkg.sv */
// --------------------------------------------------
// FIFO types: pointer, data word, write port struct
// Gray code conversion functions for both domains
// --------------------------------------------------
package afifo_pkg;

   `include "fifo_defs.svh"

   typedef logic [FIFO_PW-1:0] ptr_t;   // binary or gray pointer
   typedef logic [FIFO_DW-1:0] data_t;  // one stored word

   // write port from write controller into storage
   typedef struct packed {
      logic               en;    // write strobe
      logic [FIFO_AW-1:0] addr;  // entry select
      data_t              data;  // word to store
   } wr_port_t;

   // binary to gray, neighbours differ in one bit
   function automatic ptr_t bin_to_gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // gray to binary, xor folded down from the msb
   function automatic ptr_t gray_to_bin(input ptr_t gray);
      ptr_t bin;
      bin[FIFO_PW-1] = gray[FIFO_PW-1];  // top bit is the same
      for (int i = FIFO_PW - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

/* source/afifo_read_ctrl.sv */
// --------------------------------------------------
// read side: pointer, empty, rd_valid, gated data
// --------------------------------------------------
`timescale 1ns/1ps

module afifo_read_ctrl (
   input  logic                          read_clk,         // read clock
   input  logic                          read_rst_n,       // read reset, async low
   input  logic                          read_ready,       // reader takes the head word
   input  afifo_pkg::ptr_t               w_ptr_gray_sync,  // write pointer, gray, synced
   input  afifo_pkg::data_t              r_word,           // head word from storage
   output logic [afifo_pkg::FIFO_AW-1:0] r_addr,           // entry to read
   output afifo_pkg::ptr_t               r_ptr_gray,       // read pointer, gray, flopped
   output logic                          rd_valid,         // FIFO holds a word
   output afifo_pkg::data_t              rd_data           // head word or zero
);

   import afifo_pkg::*;

   ptr_t r_ptr_q;     // binary read pointer
   ptr_t w_ptr_bin;   // synced write pointer in binary
   logic fifo_empty;  // pointers match on both laps
   logic r_en;        // word consumed this cycle

   // empty compare
   // --------------------------------------------------
   assign w_ptr_bin = gray_to_bin(w_ptr_gray_sync);

   assign fifo_empty = (w_ptr_bin == r_ptr_q);  // same entry, same lap
   assign rd_valid   = ~fifo_empty;
   assign r_en       = read_ready & rd_valid;   // head word leaves on this edge

   assign r_addr = r_ptr_q[FIFO_AW-1:0];  // low bits address the storage

   // data out
   // --------------------------------------------------
   // storage read is a pass-through, so the head word shows up as
   // soon as the synced write pointer moves past the read pointer
   assign rd_data = rd_valid ? r_word : '0;  // zero while empty

   // read pointer
   // --------------------------------------------------
   always_ff @(posedge read_clk or negedge read_rst_n) begin
      if (!read_rst_n) begin
         r_ptr_q <= '0;
      end else if (r_en) begin
         r_ptr_q <= r_ptr_q + 1'b1;
      end
   end

   // gray export
   // --------------------------------------------------
   always_ff @(posedge read_clk or negedge read_rst_n) begin
      if (!read_rst_n) begin
         r_ptr_gray <= '0;
      end else begin
         r_ptr_gray <= bin_to_gray(r_ptr_q);  // flopped to remove glitches
      end
   end

endmodule

/* source/afifo_regfile.sv */
// --------------------------------------------------
// 4x8 FIFO storage, sync write and async read
// --------------------------------------------------
`timescale 1ns/1ps

module afifo_regfile (
   input  logic                         write_clk,  // write domain clock
   input  afifo_pkg::wr_port_t          wr_port,    // enable, address and data
   input  logic [afifo_pkg::FIFO_AW-1:0] r_addr,    // read entry from read side
   output afifo_pkg::data_t             r_word      // head word, combinational
);

   import afifo_pkg::*;

   localparam int DEPTH = 1 << FIFO_AW;  // 4 entries

   data_t mem_q [DEPTH];  // storage array

   // write port
   // --------------------------------------------------
   // only the write domain touches the array, the read side
   // never looks at an entry until its pointer has crossed over
   always_ff @(posedge write_clk) begin
      if (wr_port.en) begin
         mem_q[wr_port.addr] <= wr_port.data;  // store the pushed word
      end
   end

   // read port
   // --------------------------------------------------
   assign r_word = mem_q[r_addr];  // plain mux, no output flop

endmodule

/* source/afifo_top.sv */
// --------------------------------------------------
// dual-clock FIFO top, 4 deep by 8 wide
// --------------------------------------------------
`timescale 1ns/1ps

module afifo_top #(
   parameter int SYNC_STAGES = 2       // synchronizer depth, both directions
) (
   // write domain
   input  logic              write_clk,
   input  logic              write_rst_n,
   input  logic              push,      // push strobe
   input  afifo_pkg::data_t  push_data,
   output logic              full,      // push is dropped while high
   // read domain
   input  logic              read_clk,
   input  logic              read_rst_n,
   input  logic              read_ready,  // take the head word
   output logic              rd_valid,    // not empty
   output afifo_pkg::data_t  rd_data      // zero while empty
);

   import afifo_pkg::*;

   wr_port_t             wr_port;          // write ctrl to storage
   ptr_t                 w_ptr_gray;       // write domain
   ptr_t                 w_ptr_gray_sync;  // read domain copy
   ptr_t                 r_ptr_gray;       // read domain
   ptr_t                 r_ptr_gray_sync;  // write domain copy
   logic [FIFO_AW-1:0]   r_addr;
   data_t                r_word;

   // write side
   // --------------------------------------------------
   afifo_write_ctrl u_write_ctrl (
      .write_clk       (write_clk),
      .write_rst_n     (write_rst_n),
      .push            (push),
      .push_data       (push_data),
      .r_ptr_gray_sync (r_ptr_gray_sync),
      .full            (full),
      .wr_port         (wr_port),
      .w_ptr_gray      (w_ptr_gray)
   );

   // read pointer into the write domain
   gray_ptr_sync #(.SYNC_STAGES(SYNC_STAGES)) u_r2w_sync (
      .clk      (write_clk),
      .rst_n    (write_rst_n),
      .gray_in  (r_ptr_gray),
      .gray_out (r_ptr_gray_sync)
   );

   // storage
   // --------------------------------------------------
   afifo_regfile u_regfile (
      .write_clk (write_clk),
      .wr_port   (wr_port),
      .r_addr    (r_addr),
      .r_word    (r_word)
   );

   // read side
   // --------------------------------------------------
   // write pointer into the read domain
   gray_ptr_sync #(.SYNC_STAGES(SYNC_STAGES)) u_w2r_sync (
      .clk      (read_clk),
      .rst_n    (read_rst_n),
      .gray_in  (w_ptr_gray),
      .gray_out (w_ptr_gray_sync)
   );

   afifo_read_ctrl u_read_ctrl (
      .read_clk        (read_clk),
      .read_rst_n      (read_rst_n),
      .read_ready      (read_ready),
      .w_ptr_gray_sync (w_ptr_gray_sync),
      .r_word          (r_word),
      .r_addr          (r_addr),
      .r_ptr_gray      (r_ptr_gray),
      .rd_valid        (rd_valid),
      .rd_data         (rd_data)
   );

endmodule

/* source/afifo_write_ctrl.sv */
// --------------------------------------------------
// write side: pointer, full flag, gray pointer export
// --------------------------------------------------
`timescale 1ns/1ps

module afifo_write_ctrl (
   input  logic                 write_clk,        // write clock
   input  logic                 write_rst_n,      // write reset, async low
   input  logic                 push,             // push strobe
   input  afifo_pkg::data_t     push_data,        // word to push
   input  afifo_pkg::ptr_t      r_ptr_gray_sync,  // read pointer, gray, synced here
   output logic                 full,             // no room, pushes are dropped
   output afifo_pkg::wr_port_t  wr_port,          // write port to storage
   output afifo_pkg::ptr_t      w_ptr_gray        // write pointer, gray, flopped
);

   import afifo_pkg::*;

   ptr_t w_ptr_q;   // binary write pointer
   ptr_t r_ptr_bin; // synced read pointer in binary
   logic w_en;      // push accepted this cycle

   // full compare
   // --------------------------------------------------
   assign r_ptr_bin = gray_to_bin(r_ptr_gray_sync);

   // same entry, opposite lap
   assign full = (w_ptr_q[FIFO_AW-1:0] == r_ptr_bin[FIFO_AW-1:0]) &&
                 (w_ptr_q[FIFO_AW] != r_ptr_bin[FIFO_AW]);

   assign w_en = push & ~full;  // push into a full FIFO is lost

   // storage write port
   assign wr_port.en   = w_en;
   assign wr_port.addr = w_ptr_q[FIFO_AW-1:0];  // low bits pick the entry
   assign wr_port.data = push_data;

   // write pointer
   // --------------------------------------------------
   always_ff @(posedge write_clk or negedge write_rst_n) begin
      if (!write_rst_n) begin
         w_ptr_q <= '0;
      end else if (w_en) begin
         w_ptr_q <= w_ptr_q + 1'b1;  // wraps through both laps
      end
   end

   // gray export
   // --------------------------------------------------
   // flopped so the crossing bus carries no decode glitches,
   // the read side sees a new word one write_clk after the accept
   always_ff @(posedge write_clk or negedge write_rst_n) begin
      if (!write_rst_n) begin
         w_ptr_gray <= '0;
      end else begin
         w_ptr_gray <= bin_to_gray(w_ptr_q);
      end
   end

endmodule

/* source/gray_ptr_sync.sv */
// --------------------------------------------------
// multi-flop synchronizer for a gray coded pointer
// --------------------------------------------------
`timescale 1ns/1ps

module gray_ptr_sync #(
   parameter int SYNC_STAGES = 2          // flops in the chain, 2 or more
) (
   input  logic             clk,          // destination clock
   input  logic             rst_n,        // destination reset, async low
   input  afifo_pkg::ptr_t  gray_in,      // gray pointer from the source domain
   output afifo_pkg::ptr_t  gray_out      // same pointer, SYNC_STAGES later
);

   import afifo_pkg::*;

   // stage 0 is the capture flop, last stage is the output
   ptr_t [SYNC_STAGES-1:0] sync_q;

   // shift chain
   // --------------------------------------------------
   // gray input moves one bit per source step, so a late capture
   // still lands on either the old or the new pointer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], gray_in};  // shift towards the top
      end
   end

   assign gray_out = sync_q[SYNC_STAGES-1];  // settled value

endmodule
